/* hdl/rob_commit.sv */
/*
  Commit stage of the retirement buffer. Holds the oldest pending exception,
  retires the head group, releases its rename ids and drives the flush.
*/
`timescale 1ns/1ns

module rob_commit
  import rob_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  rob_head_t i_head,
  input  done_rpt_t i_done [DONE_PORTS],
  input  done_rpt_t i_fe_exc,
  output logic      o_head_pop,
  output logic      o_kill,
  output commit_t   o_commit,
  output rnid_upd_t o_rnid_upd,
  output logic      o_cre_ret
);

  except_rec_t     r_exc;
  except_rec_t     w_exc_next;
  except_rec_t     w_cand [EXC_SRCS];
  logic            w_exc_hit;         // Held exception belongs to head group
  logic            w_exc_live;
  logic            r_kill_d1;
  grp_id_t         w_exc_tree;
  grp_id_t         w_later;
  logic [PC_W-1:0] w_epc;
  commit_t         w_commit;
  rnid_upd_t       w_rnid_upd;

  assign o_head_pop = i_head.valid;

  // ------------------------------------------------------------------
  // Oldest exception
  // ------------------------------------------------------------------
  always_comb begin
    for (int p = 0; p < DONE_PORTS; p++) begin
      w_cand[p].valid  = i_done[p].valid & i_done[p].except_valid;
      w_cand[p].cmt_id = i_done[p].cmt_id;
      w_cand[p].grp_id = i_done[p].grp_id;
      w_cand[p].typ    = i_done[p].except_type;
    end
    w_cand[DONE_PORTS].valid  = i_fe_exc.valid & i_fe_exc.except_valid;
    w_cand[DONE_PORTS].cmt_id = i_fe_exc.cmt_id;
    w_cand[DONE_PORTS].grp_id = i_fe_exc.grp_id;
    w_cand[DONE_PORTS].typ    = i_fe_exc.except_type;
  end

  assign w_exc_hit  = r_exc.valid & (r_exc.cmt_id == i_head.cmt_id);
  assign w_exc_live = i_head.valid & w_exc_hit &
                      (|(r_exc.grp_id & i_head.grp_id & ~i_head.dead));

  always_comb begin
    w_exc_next = r_exc;
    if (i_head.valid && w_exc_hit) begin
      w_exc_next.valid = 1'b0;  // Retired with its group
    end
    if (!o_kill) begin
      for (int s = 0; s < EXC_SRCS; s++) begin
        if (w_cand[s].valid &&
            (!w_exc_next.valid ||
             id_is_older(w_cand[s].cmt_id, w_cand[s].grp_id,
                         w_exc_next.cmt_id, w_exc_next.grp_id))) begin
          w_exc_next = w_cand[s];
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Commit record
  // ------------------------------------------------------------------
  always_comb begin
    w_exc_tree[0] = r_exc.grp_id[0];
    for (int d = 1; d < DISP_SIZE; d++) begin
      w_exc_tree[d] = w_exc_tree[d-1] | r_exc.grp_id[d];
    end
    w_epc = '0;
    for (int d = DISP_SIZE - 1; d >= 0; d--) begin
      if (r_exc.grp_id[d]) begin
        w_epc = i_head.payload[d].pc;  // Lowest excepting slot wins
      end
    end
  end

  assign w_later = {w_exc_tree[DISP_SIZE-2:0], 1'b0};  // Slots after the fault

  always_comb begin
    w_commit.valid        = i_head.valid;
    w_commit.cmt_id       = i_head.cmt_id;
    w_commit.grp_id       = i_head.grp_id;
    w_commit.dead_id      = (i_head.dead | (w_exc_live ? w_later : '0)) & i_head.grp_id;
    w_commit.except_valid = w_exc_live ? (r_exc.grp_id & i_head.grp_id) : '0;
    w_commit.except_type  = w_exc_live ? r_exc.typ : EXC_NONE;
    w_commit.epc          = w_exc_live ? w_epc : '0;

    w_rnid_upd.commit  = i_head.valid;
    w_rnid_upd.dead_id = w_commit.dead_id;
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_rnid_upd.rnid_valid[d] = i_head.payload[d].wr_valid & i_head.grp_id[d];
      w_rnid_upd.regidx[d]     = i_head.payload[d].regidx;
      w_rnid_upd.rnid[d]       = i_head.payload[d].rnid;
      w_rnid_upd.old_rnid[d]   = i_head.payload[d].old_rnid;
    end
  end

  // Flush spans the commit cycle and the one after
  assign o_kill = w_exc_live | r_kill_d1;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_exc      <= '0;
      r_kill_d1  <= 1'b0;
      o_commit   <= '0;
      o_rnid_upd <= '0;
      o_cre_ret  <= 1'b0;
    end else begin
      r_exc      <= w_exc_next;
      r_kill_d1  <= w_exc_live;
      o_commit   <= w_commit;
      o_rnid_upd <= w_rnid_upd;
      o_cre_ret  <= i_head.valid;  // One credit per retired group
    end
  end

endmodule

/* hdl/rob_dispatch.sv */
/*
  Dispatch front of the retirement buffer. Owns the tail commit id, builds
  the entry written for each dispatched group and reports illegal slots.
*/
`timescale 1ns/1ns

module rob_dispatch
  import rob_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_disp_valid,
  input  disp_grp_t  i_disp_grp,
  input  logic       i_kill,
  input  logic       i_head_pop,
  output rob_alloc_t o_alloc,
  output done_rpt_t  o_fe_exc,
  output cmt_id_t    o_new_cmt_id
);

  cmt_id_t              r_tail_id;
  logic [CMT_ENTRY_W:0] r_inflight;   // Groups held, 0 to CMT_ENTRY_SIZE
  logic                 w_full;
  logic                 w_accept;
  logic                 w_fe_valid;
  grp_id_t              w_grp_id;
  grp_id_t              w_illegal;
  grp_id_t              w_ill_tree;   // Set from the first illegal slot upward
  grp_id_t              w_ill_first;

  assign w_full   = (r_inflight == (CMT_ENTRY_W + 1)'(CMT_ENTRY_SIZE));
  assign w_accept = i_disp_valid & ~w_full;  // A full buffer never gets overwritten

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_grp_id[d]  = i_disp_grp[d].valid;
      w_illegal[d] = i_disp_grp[d].valid & i_disp_grp[d].illegal;
    end
    w_ill_tree[0] = w_illegal[0];
    for (int d = 1; d < DISP_SIZE; d++) begin
      w_ill_tree[d] = w_ill_tree[d-1] | w_illegal[d];
    end
  end

  assign w_ill_first = w_illegal & ~{w_ill_tree[DISP_SIZE-2:0], 1'b0};

  // ------------------------------------------------------------------
  // New entry
  // ------------------------------------------------------------------
  always_comb begin
    o_alloc.valid       = w_accept;
    o_alloc.cmt_id      = r_tail_id;
    o_alloc.grp_id      = w_grp_id;
    o_alloc.done_grp_id = i_kill ? w_grp_id : (w_grp_id & w_ill_tree);
    o_alloc.dead        = {DISP_SIZE{i_kill}} & w_grp_id;  // Flush in progress
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_alloc.payload[d].pc       = i_disp_grp[d].pc;
      o_alloc.payload[d].wr_valid = i_disp_grp[d].wr_valid;
      o_alloc.payload[d].regidx   = i_disp_grp[d].regidx;
      o_alloc.payload[d].rnid     = i_disp_grp[d].rnid;
      o_alloc.payload[d].old_rnid = i_disp_grp[d].old_rnid;
    end
  end

  // Illegal instruction report, dropped for groups written dead
  assign w_fe_valid = w_accept & ~i_kill & (|w_ill_first);

  assign o_fe_exc.valid        = w_fe_valid;
  assign o_fe_exc.cmt_id       = r_tail_id;
  assign o_fe_exc.grp_id       = w_ill_first;
  assign o_fe_exc.except_valid = w_fe_valid;
  assign o_fe_exc.except_type  = ILLEGAL_INST;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail_id  <= '0;
      r_inflight <= '0;
    end else begin
      if (w_accept) begin
        r_tail_id <= r_tail_id + 1'b1;
      end
      case ({w_accept, i_head_pop})
        2'b10:   r_inflight <= r_inflight + 1'b1;
        2'b01:   r_inflight <= r_inflight - 1'b1;
        default: r_inflight <= r_inflight;
      endcase
    end
  end

  assign o_new_cmt_id = r_tail_id;

endmodule

/* hdl/rob_entry_array.sv */
/*
  Entry store of the retirement buffer. Keeps per-entry status and payload,
  merges done reports and presents the head group once it is fully done.
*/
`timescale 1ns/1ns

module rob_entry_array
  import rob_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  rob_alloc_t i_alloc,
  input  done_rpt_t  i_done [DONE_PORTS],
  input  logic       i_kill,
  input  logic       i_head_pop,
  output rob_head_t  o_head
);

  logic [CMT_ENTRY_SIZE-1:0] r_valid;
  grp_id_t                   r_grp_id  [CMT_ENTRY_SIZE];
  grp_id_t                   r_done    [CMT_ENTRY_SIZE];
  grp_id_t                   r_dead    [CMT_ENTRY_SIZE];
  rob_payload_t              r_payload [CMT_ENTRY_SIZE];

  cmt_id_t                   r_head_id;
  logic [CMT_ENTRY_W-1:0]    w_head_idx;
  logic [CMT_ENTRY_W-1:0]    w_alloc_idx;
  grp_id_t                   w_done_set [CMT_ENTRY_SIZE];
  logic                      w_head_all_done;

  assign w_head_idx  = r_head_id[CMT_ENTRY_W-1:0];
  assign w_alloc_idx = i_alloc.cmt_id[CMT_ENTRY_W-1:0];

  // ------------------------------------------------------------------
  // Done report decode
  // ------------------------------------------------------------------
  always_comb begin
    for (int e = 0; e < CMT_ENTRY_SIZE; e++) begin
      w_done_set[e] = '0;
      for (int p = 0; p < DONE_PORTS; p++) begin
        if (i_done[p].valid &&
            (i_done[p].cmt_id[CMT_ENTRY_W-1:0] == CMT_ENTRY_W'(e))) begin
          w_done_set[e] = w_done_set[e] | i_done[p].grp_id;
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Entry status
  // ------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      for (int e = 0; e < CMT_ENTRY_SIZE; e++) begin
        r_grp_id[e] <= '0;
        r_done[e]   <= '0;
        r_dead[e]   <= '0;
      end
    end else begin
      for (int e = 0; e < CMT_ENTRY_SIZE; e++) begin
        if (i_alloc.valid && (w_alloc_idx == CMT_ENTRY_W'(e))) begin
          r_valid[e]  <= 1'b1;
          r_grp_id[e] <= i_alloc.grp_id;
          r_done[e]   <= i_alloc.done_grp_id;
          r_dead[e]   <= i_alloc.dead;
        end else if (i_head_pop && (w_head_idx == CMT_ENTRY_W'(e))) begin
          r_valid[e] <= 1'b0;          // Retired
          r_done[e]  <= '0;
          r_dead[e]  <= '0;
        end else if (r_valid[e]) begin
          if (i_kill) begin
            // Flush marks every slot dead and done
            r_done[e] <= r_grp_id[e];
            r_dead[e] <= r_dead[e] | r_grp_id[e];
          end else begin
            r_done[e] <= r_done[e] | (w_done_set[e] & r_grp_id[e]);
          end
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_alloc.valid) begin
      r_payload[w_alloc_idx] <= i_alloc.payload;
    end
  end

  // Head pointer, one group per pop
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_id <= '0;
    end else if (i_head_pop) begin
      r_head_id <= r_head_id + 1'b1;
    end
  end

  assign w_head_all_done = ((r_done[w_head_idx] & r_grp_id[w_head_idx]) ==
                            r_grp_id[w_head_idx]);

  assign o_head.valid   = r_valid[w_head_idx] & w_head_all_done;
  assign o_head.cmt_id  = r_head_id;
  assign o_head.grp_id  = r_grp_id[w_head_idx];
  assign o_head.dead    = r_dead[w_head_idx];
  assign o_head.payload = r_payload[w_head_idx];

endmodule

/* hdl/rob_pkg.sv */
/*
  Sizes, exception codes and bus structs shared by the retirement buffer.
  Modules pull these in with a wildcard import in their header.
*/
package rob_pkg;

  localparam int DISP_SIZE      = 2;   // Instructions per dispatch group
  localparam int CMT_ENTRY_SIZE = 8;
  localparam int CMT_ENTRY_W    = 3;
  localparam int CMT_ID_W       = 4;   // Index plus wrap bit
  localparam int DONE_PORTS     = 2;
  localparam int EXC_SRCS       = DONE_PORTS + 1;  // Done ports plus front end
  localparam int PC_W           = 32;
  localparam int REGIDX_W       = 5;
  localparam int RNID_W         = 6;

  typedef logic [CMT_ID_W-1:0]  cmt_id_t;
  typedef logic [DISP_SIZE-1:0] grp_id_t;

  typedef enum logic [3:0] {
    EXC_NONE        = 4'd0,
    INST_ACC_FAULT  = 4'd1,
    ILLEGAL_INST    = 4'd2,
    LOAD_ACC_FAULT  = 4'd5,
    STORE_ACC_FAULT = 4'd7,
    ECALL_M         = 4'd11
  } except_t;

  typedef struct packed {
    logic                valid;
    logic                illegal;
    logic [PC_W-1:0]     pc;
    logic                wr_valid;
    logic [REGIDX_W-1:0] regidx;
    logic [RNID_W-1:0]   rnid;
    logic [RNID_W-1:0]   old_rnid;
  } disp_inst_t;

  typedef disp_inst_t [DISP_SIZE-1:0] disp_grp_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    grp_id_t grp_id;        // One-hot slot
    logic    except_valid;
    except_t except_type;
  } done_rpt_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    grp_id_t grp_id;
    except_t typ;
  } except_rec_t;

  // Per-slot payload kept until commit
  typedef struct packed {
    logic [PC_W-1:0]     pc;
    logic                wr_valid;
    logic [REGIDX_W-1:0] regidx;
    logic [RNID_W-1:0]   rnid;
    logic [RNID_W-1:0]   old_rnid;
  } rob_slot_t;

  typedef rob_slot_t [DISP_SIZE-1:0] rob_payload_t;

  typedef struct packed {
    logic         valid;
    cmt_id_t      cmt_id;
    grp_id_t      grp_id;
    grp_id_t      done_grp_id;  // Slots done at allocation
    grp_id_t      dead;
    rob_payload_t payload;
  } rob_alloc_t;

  typedef struct packed {
    logic         valid;        // Head entry present and fully done
    cmt_id_t      cmt_id;
    grp_id_t      grp_id;
    grp_id_t      dead;
    rob_payload_t payload;
  } rob_head_t;

  typedef struct packed {
    logic            valid;
    cmt_id_t         cmt_id;
    grp_id_t         grp_id;
    grp_id_t         dead_id;
    grp_id_t         except_valid;
    except_t         except_type;
    logic [PC_W-1:0] epc;
  } commit_t;

  typedef struct packed {
    logic                               commit;
    grp_id_t                            rnid_valid;
    logic [DISP_SIZE-1:0][REGIDX_W-1:0] regidx;
    logic [DISP_SIZE-1:0][RNID_W-1:0]   rnid;
    logic [DISP_SIZE-1:0][RNID_W-1:0]   old_rnid;
    grp_id_t                            dead_id;
  } rnid_upd_t;

  // Age compare of two (cmt_id, slot) pairs, true when A is older
  function automatic logic id_is_older(cmt_id_t a_id, grp_id_t a_grp,
                                       cmt_id_t b_id, grp_id_t b_grp);
    logic    same_wrap;
    logic    idx_lt;
    logic    idx_gt;
    grp_id_t a_low;
    grp_id_t b_low;
    same_wrap = (a_id[CMT_ID_W-1] == b_id[CMT_ID_W-1]);
    idx_lt    = (a_id[CMT_ENTRY_W-1:0] < b_id[CMT_ENTRY_W-1:0]);
    idx_gt    = (a_id[CMT_ENTRY_W-1:0] > b_id[CMT_ENTRY_W-1:0]);
    a_low     = a_grp & (~a_grp + 1'b1);  // Lowest set slot, one-hot
    b_low     = b_grp & (~b_grp + 1'b1);
    return (idx_lt & same_wrap) | (idx_gt & ~same_wrap) |
           ((a_id == b_id) & (a_low < b_low));
  endfunction

endpackage

/* hdl/rob_top.sv */
/*
  Top of the in-order retirement buffer. Connects dispatch, entry store
  and commit stage.
*/
`timescale 1ns/1ns

module rob_top
  import rob_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_disp_valid,
  input  disp_grp_t i_disp_grp,
  input  done_rpt_t i_done [DONE_PORTS],
  output cmt_id_t   o_new_cmt_id,
  output commit_t   o_commit,
  output rnid_upd_t o_rnid_upd,
  output logic      o_cre_ret
);

  rob_alloc_t alloc;
  done_rpt_t  fe_exc;
  rob_head_t  head;
  logic       kill;
  logic       head_pop;

  rob_dispatch rob_dispatch_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_disp_grp   (i_disp_grp),
    .i_kill       (kill),
    .i_head_pop   (head_pop),
    .o_alloc      (alloc),
    .o_fe_exc     (fe_exc),
    .o_new_cmt_id (o_new_cmt_id)
  );

  rob_entry_array rob_entry_array_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_alloc    (alloc),
    .i_done     (i_done),
    .i_kill     (kill),
    .i_head_pop (head_pop),
    .o_head     (head)
  );

  rob_commit rob_commit_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_head     (head),
    .i_done     (i_done),
    .i_fe_exc   (fe_exc),
    .o_head_pop (head_pop),
    .o_kill     (kill),
    .o_commit   (o_commit),
    .o_rnid_upd (o_rnid_upd),
    .o_cre_ret  (o_cre_ret)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the retirement buffer testbench with Verilator and runs it.
# Exit status is 0 only when the testbench reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module rob_tb -o rob_sim

# Keep running after an assertion error so that the testbench can report it
sim_out=$(./obj_dir/rob_sim +verilator+error+limit+1000)
echo "$sim_out"

if grep -qx "Testbench passed" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

/* sim.f */
hdl/rob_pkg.sv
hdl/rob_dispatch.sv
hdl/rob_entry_array.sv
hdl/rob_commit.sv
hdl/rob_top.sv
verif/rob_props.sv
verif/rob_tb.sv

/* verif/rob_props.sv */
/*
  Protocol assertions on the retirement buffer top, attached with bind.
  Each assertion also keeps its own failure count for the testbench.
*/
`timescale 1ns/1ns

module rob_props
  import rob_pkg::*;
(
  input logic    i_clk,
  input logic    i_reset_n,
  input logic    i_disp_valid,
  input logic    i_cre_ret,
  input commit_t i_commit
);

  logic [CMT_ENTRY_W:0] r_held;     // Groups dispatched and not yet credited
  cmt_id_t              r_last_id;
  logic                 r_seen;     // A commit has happened since reset
  int                   fail_overfill = 0;
  int                   fail_credit   = 0;
  int                   fail_step     = 0;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_held    <= '0;
      r_last_id <= '0;
      r_seen    <= 1'b0;
    end else begin
      r_held <= r_held + (CMT_ENTRY_W + 1)'(i_disp_valid) - (CMT_ENTRY_W + 1)'(i_cre_ret);
      if (i_commit.valid) begin
        r_last_id <= i_commit.cmt_id;
        r_seen    <= 1'b1;
      end
    end
  end

  no_overfill: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |-> (r_held < (CMT_ENTRY_W + 1)'(CMT_ENTRY_SIZE)))
    else begin
      $error("dispatch while every entry is held without credit");
      fail_overfill++;
    end

  credit_matches_commit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_cre_ret == i_commit.valid)
    else begin
      $error("credit pulse differs from commit valid");
      fail_credit++;
    end

  commit_id_steps: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_commit.valid && r_seen) |-> (i_commit.cmt_id == r_last_id + 1'b1))
    else begin
      $error("commit id did not step by one");
      fail_step++;
    end

endmodule

bind rob_top rob_props rob_props_i (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .i_disp_valid (i_disp_valid),
  .i_cre_ret    (o_cre_ret),
  .i_commit     (o_commit)
);

/* verif/rob_tb.sv */
/*
  Directed testbench for the retirement buffer. Each test is a task; a
  monitor checks every commit against a queue of expected records.
*/
`timescale 1ns/1ns

module rob_tb
  import rob_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 2000;  // All tests need a few hundred cycles

  logic      clk;
  logic      reset_n;
  logic      disp_valid;
  disp_grp_t disp_grp;
  done_rpt_t done [DONE_PORTS];
  cmt_id_t   new_cmt_id;
  commit_t   commit;
  rnid_upd_t rnid_upd;
  logic      cre_ret;

  commit_t   exp_commit_q [$];   // Expected records in dispatch order
  rnid_upd_t exp_rnid_q [$];
  cmt_id_t   tail_id = '0;       // Model of the next commit id
  int        errors = 0;
  int        test_errors = 0;
  int        tests_run = 0;
  int        tests_failed = 0;
  int        cycle_cnt = 0;
  int        commit_cnt = 0;
  int        credit_cnt = 0;
  int        disp_cnt = 0;

  rob_top rob_top_i (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_disp_valid (disp_valid),
    .i_disp_grp   (disp_grp),
    .i_done       (done),
    .o_new_cmt_id (new_cmt_id),
    .o_commit     (commit),
    .o_rnid_upd   (rnid_upd),
    .o_cre_ret    (cre_ret)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------
  // Reporting and compare tasks
  // --------------------------------------------------------------------
  task automatic flag_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic flag_failure(input string msg);
    $display("%s (at %0t)", msg, $time);
    errors++;
    test_errors++;
  endtask

  function automatic string commit_text(input commit_t c);
    return $sformatf("v %b id %h grp %b dead %b exc %b type %0d epc %h", c.valid,
                     c.cmt_id, c.grp_id, c.dead_id, c.except_valid, c.except_type, c.epc);
  endfunction

  task automatic check_commit(input commit_t got, input commit_t exp);
    if (got !== exp) begin
      flag_mismatch($sformatf("commit got %s expected %s", commit_text(got), commit_text(exp)));
    end
  endtask

  task automatic check_rnid(input rnid_upd_t got, input rnid_upd_t exp);
    rnid_upd_t g;
    rnid_upd_t e;
    g = got;
    e = exp;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (!e.rnid_valid[d]) begin   // Payload of a slot without a write is don't care
        g.regidx[d]   = '0;
        g.rnid[d]     = '0;
        g.old_rnid[d] = '0;
        e.regidx[d]   = '0;
        e.rnid[d]     = '0;
        e.old_rnid[d] = '0;
      end
    end
    if (g !== e) begin
      flag_mismatch($sformatf("rename release got %h expected %h", g, e));
    end
  endtask

  task automatic check_credit(input int got, input int exp);
    if (got != exp) begin
      flag_mismatch($sformatf("credit count got %0d expected %0d", got, exp));
    end
  endtask

  task automatic check_id(input cmt_id_t got, input cmt_id_t exp);
    if (got !== exp) begin
      flag_mismatch($sformatf("new commit id got %h expected %h", got, exp));
    end
  endtask

  // Commit monitor, sampled away from the clock edge
  always @(negedge clk) begin
    if (reset_n) begin
      if (cre_ret) credit_cnt++;
      if (rnid_upd.commit !== commit.valid) begin
        flag_mismatch($sformatf("rename release commit %b with commit valid %b",
                                rnid_upd.commit, commit.valid));
      end
      if (commit.valid) begin
        commit_cnt++;
        if (exp_commit_q.size() == 0) begin
          flag_failure("a group committed although none was outstanding");
        end else begin
          check_commit(commit, exp_commit_q.pop_front());
          check_rnid(rnid_upd, exp_rnid_q.pop_front());
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // Stimulus and reference model
  // --------------------------------------------------------------------
  task automatic drive_cycle(input logic dv, input disp_grp_t g,
                             input done_rpt_t d0, input done_rpt_t d1);
    @(posedge clk);
    #1;
    disp_valid = dv;
    disp_grp   = g;
    done[0]    = d0;
    done[1]    = d1;
  endtask

  function automatic disp_grp_t random_group(input grp_id_t valid, input grp_id_t illegal);
    disp_grp_t g;
    for (int d = 0; d < DISP_SIZE; d++) begin
      g[d].valid    = valid[d];
      g[d].illegal  = illegal[d];
      g[d].pc       = PC_W'($urandom) & ~32'h3;
      g[d].wr_valid = 1'($urandom);
      g[d].regidx   = REGIDX_W'($urandom);
      g[d].rnid     = RNID_W'($urandom);
      g[d].old_rnid = RNID_W'($urandom);
    end
    return g;
  endfunction

  function automatic done_rpt_t make_report(input logic v, input cmt_id_t id,
                                            input grp_id_t slot, input logic ex,
                                            input except_t typ);
    done_rpt_t r;
    r.valid        = v;
    r.cmt_id       = id;
    r.grp_id       = slot;
    r.except_valid = ex;
    r.except_type  = typ;
    return r;
  endfunction

  // Expected records; exc is the one-hot faulting slot, killed means flushed
  task automatic expect_group(input disp_grp_t g, input cmt_id_t id, input grp_id_t exc,
                              input except_t typ, input logic killed);
    commit_t   c;
    rnid_upd_t r;
    grp_id_t   valid;
    grp_id_t   after;   // Slots younger than the fault
    logic      seen;
    seen  = 1'b0;
    after = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      valid[d] = g[d].valid;
      after[d] = seen;
      seen     = seen | exc[d];
    end
    c        = '0;
    c.valid  = 1'b1;
    c.cmt_id = id;
    c.grp_id = valid;
    if (killed) begin
      c.dead_id = valid;
    end else if (exc != '0) begin
      c.dead_id      = after & valid;
      c.except_valid = exc;
      c.except_type  = typ;
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (exc[d]) c.epc = g[d].pc;
      end
    end
    r         = '0;
    r.commit  = 1'b1;
    r.dead_id = c.dead_id;
    for (int d = 0; d < DISP_SIZE; d++) begin
      r.rnid_valid[d] = g[d].valid & g[d].wr_valid;
      r.regidx[d]     = g[d].regidx;
      r.rnid[d]       = g[d].rnid;
      r.old_rnid[d]   = g[d].old_rnid;
    end
    exp_commit_q.push_back(c);
    exp_rnid_q.push_back(r);
  endtask

  task automatic send_group(input disp_grp_t g, input grp_id_t exc, input except_t typ,
                            input logic killed, output cmt_id_t id);
    drive_cycle(1'b1, g, '0, '0);
    check_id(new_cmt_id, tail_id);
    id = tail_id;
    expect_group(g, tail_id, exc, typ, killed);
    tail_id = tail_id + 1'b1;
    disp_cnt++;
  endtask

  task automatic report_done(input cmt_id_t id, input grp_id_t slots);
    drive_cycle(1'b0, '0, make_report(slots[0], id, 2'b01, 1'b0, EXC_NONE),
                make_report(slots[1], id, 2'b10, 1'b0, EXC_NONE));
  endtask

  task automatic wait_drain();
    drive_cycle(1'b0, '0, '0, '0);
    while (exp_commit_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);   // Room for a stray extra commit to show up
  endtask

  task automatic finish_test(input string name);
    string verdict;
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
      verdict = "FAILED";
    end else begin
      verdict = "ok";
    end
    $display("test %-10s %s", name, verdict);
    test_errors = 0;
  endtask

  // --------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------
  task automatic test_in_order();
    cmt_id_t id [4];
    int      seen;
    for (int k = 0; k < 4; k++) send_group(random_group(2'b11, 2'b00), '0, EXC_NONE, 1'b0, id[k]);
    for (int k = 3; k >= 1; k--) report_done(id[k], 2'b11);
    seen = commit_cnt;
    repeat (3) drive_cycle(1'b0, '0, '0, '0);
    if (commit_cnt != seen) flag_failure("a group committed while the oldest was still pending");
    report_done(id[0], 2'b11);
    wait_drain();
    finish_test("in_order");
  endtask

  task automatic test_rename();
    cmt_id_t id;
    send_group(random_group(2'b11, 2'b00), '0, EXC_NONE, 1'b0, id);
    report_done(id, 2'b11);
    send_group(random_group(2'b01, 2'b00), '0, EXC_NONE, 1'b0, id);  // Single-slot group
    report_done(id, 2'b01);
    send_group(random_group(2'b11, 2'b00), '0, EXC_NONE, 1'b0, id);
    report_done(id, 2'b11);
    wait_drain();
    finish_test("rename");
  endtask

  task automatic test_illegal();
    cmt_id_t id [3];
    send_group(random_group(2'b11, 2'b10), 2'b10, ILLEGAL_INST, 1'b0, id[0]);
    send_group(random_group(2'b11, 2'b00), '0, EXC_NONE, 1'b1, id[1]);
    send_group(random_group(2'b11, 2'b00), '0, EXC_NONE, 1'b1, id[2]);
    report_done(id[0], 2'b01);   // Slot 1 gets no report
    wait_drain();
    finish_test("illegal");
  endtask

  task automatic test_oldest_exc();
    cmt_id_t id [4];
    for (int k = 0; k < 4; k++) begin
      send_group(random_group(2'b11, 2'b00), (k == 1) ? 2'b01 : 2'b00, LOAD_ACC_FAULT,
                 (k >= 2), id[k]);
    end
    // Younger fault first, then the older one
    drive_cycle(1'b0, '0, make_report(1'b1, id[2], 2'b01, 1'b1, STORE_ACC_FAULT),
                make_report(1'b1, id[2], 2'b10, 1'b0, EXC_NONE));
    drive_cycle(1'b0, '0, make_report(1'b1, id[1], 2'b01, 1'b1, LOAD_ACC_FAULT),
                make_report(1'b1, id[1], 2'b10, 1'b0, EXC_NONE));
    report_done(id[0], 2'b11);
    wait_drain();
    finish_test("oldest_exc");
  endtask

  task automatic test_credits();
    cmt_id_t id [CMT_ENTRY_SIZE];
    int      base;
    base = credit_cnt;
    for (int k = 0; k < CMT_ENTRY_SIZE; k++) begin
      send_group(random_group(2'b11, 2'b00), '0, EXC_NONE, 1'b0, id[k]);
    end
    for (int k = 0; k < CMT_ENTRY_SIZE; k++) report_done(id[k], 2'b11);
    wait_drain();
    check_credit(credit_cnt - base, CMT_ENTRY_SIZE);
    check_credit(credit_cnt, disp_cnt);
    finish_test("credits");
  endtask

  initial begin
    void'($urandom(52638));
    reset_n    = 1'b0;
    disp_valid = 1'b0;
    disp_grp   = '0;
    done[0]    = '0;
    done[1]    = '0;
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;

    test_in_order();
    test_rename();
    test_illegal();
    test_oldest_exc();
    test_credits();

    // Assertion failures from the bound checker count as errors too
    errors += rob_top_i.rob_props_i.fail_overfill + rob_top_i.rob_props_i.fail_credit +
              rob_top_i.rob_props_i.fail_step;
    $display("tests %0d, failed %0d, errors %0d, commits %0d, credits %0d",
             tests_run, tests_failed, errors, commit_cnt, credit_cnt);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
